// File: files.f
+incdir+include
src/agu_pkg.sv
src/agu_loop_nest.sv
src/agu_offset_a.sv
src/agu_offset_b.sv
src/agu_top.sv
dv/agu_tb.sv

// File: dv/agu_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AGU testbench: random stimulus on both channels, checked
// each cycle against a behavioral model of the loops and offsets
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "agu_settings.svh"

module agu_tb;

    import agu_pkg::*;

    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 8;
    localparam int WRAP_CYCLES   = 1200;
    localparam int NORMAL_CYCLES = 200;
    localparam int SEQ_CYCLES    = 400;
    localparam int CBS_CYCLES    = 400;
    localparam int MIXED_CYCLES  = 2000;
    // eight resets in all, each followed by one settle cycle
    localparam int TOTAL_CYCLES  = 8 * (RESET_CYCLES + 1) + WRAP_CYCLES + NORMAL_CYCLES + 1
                                 + 3 * SEQ_CYCLES + CBS_CYCLES + MIXED_CYCLES;

    logic      clk;
    logic      rstn;
    logic      add_a;
    logic      add_b;
    logic      clr;
    mac_mode_e mode;
    logic      mac_en;
    addr_t     base_a;
    addr_t     base_b;
    stride_t   stride_a;
    stride_t   stride_b;
    count_t    a_loop0_max, a_loop1_max, a_loop2_max, a_loop3_max;
    count_t    b_loop0_max, b_loop1_max, b_loop2_max, b_loop3_max;
    full_t     full_a;
    full_t     full_b;
    addr_t     addr_a;
    addr_t     addr_b;

    // model state, index 0 is channel a and 1 is channel b
    count_t      m_cnt [2][`AGU_LOOP_DEPTH];
    addr_t       m_inner [2];
    addr_t       m_outer [2];
    int          wraps [2];
    int          cbs_outer_steps;
    int unsigned seed_val;

    agu_top agu_top_i (
        .clk         (clk),
        .rstn        (rstn),
        .add_a       (add_a),
        .add_b       (add_b),
        .clr         (clr),
        .mode        (mode),
        .mac_en      (mac_en),
        .base_a      (base_a),
        .stride_a    (stride_a),
        .a_loop0_max (a_loop0_max),
        .a_loop1_max (a_loop1_max),
        .a_loop2_max (a_loop2_max),
        .a_loop3_max (a_loop3_max),
        .base_b      (base_b),
        .stride_b    (stride_b),
        .b_loop0_max (b_loop0_max),
        .b_loop1_max (b_loop1_max),
        .b_loop2_max (b_loop2_max),
        .b_loop3_max (b_loop3_max),
        .full_a      (full_a),
        .full_b      (full_b),
        .addr_a      (addr_a),
        .addr_b      (addr_b)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic count_t max_of(input int ch, input int lvl);
        count_t m;
        case (lvl)
            0:       m = (ch == 0) ? a_loop0_max : b_loop0_max;
            1:       m = (ch == 0) ? a_loop1_max : b_loop1_max;
            2:       m = (ch == 0) ? a_loop2_max : b_loop2_max;
            default: m = (ch == 0) ? a_loop3_max : b_loop3_max;
        endcase
        return m;
    endfunction

    function automatic full_t full_of(input int ch);
        full_t f;
        logic  all_max;
        all_max = 1'b1;
        for (int k = 0; k < `AGU_LOOP_DEPTH; k++) begin
            all_max = all_max && (m_cnt[ch][k] == max_of(ch, k));
            f[k] = all_max;
        end
        return f;
    endfunction

    // flags with every counter at zero
    function automatic full_t reset_full(input int ch);
        full_t f;
        logic  all_zero;
        all_zero = 1'b1;
        for (int k = 0; k < `AGU_LOOP_DEPTH; k++) begin
            all_zero = all_zero && (max_of(ch, k) == '0);
            f[k] = all_zero;
        end
        return f;
    endfunction

    // ASE, SAE or SBE
    function automatic logic is_seq_mode(input mac_mode_e m);
        return (m == MODE_ASE) || (m == MODE_SAE) || (m == MODE_SBE);
    endfunction

    function automatic addr_t model_addr(input int ch);
        if (ch == 0)
            return base_a + m_inner[0] + m_outer[0];
        return base_b + m_inner[1] + m_outer[1];
    endfunction

    task automatic reset_model();
        for (int ch = 0; ch < 2; ch++) begin
            for (int k = 0; k < `AGU_LOOP_DEPTH; k++)
                m_cnt[ch][k] = '0;
            m_inner[ch] = '0;
            m_outer[ch] = '0;
            wraps[ch]   = 0;
        end
        cbs_outer_steps = 0;
    endtask

    // odometer with carry into the next level on wrap
    task automatic advance_counters(input int ch, input logic strobe);
        logic carry;
        carry = strobe;
        for (int k = 0; k < `AGU_LOOP_DEPTH; k++) begin
            if (carry) begin
                if (m_cnt[ch][k] == max_of(ch, k)) begin
                    m_cnt[ch][k] = '0;
                end else begin
                    m_cnt[ch][k] = m_cnt[ch][k] + 1'b1;
                    carry = 1'b0;
                end
            end
        end
        if (carry)
            wraps[ch]++;    // whole nest rolled over
    endtask

    task automatic update_a(input full_t f);
        addr_t step;
        step = addr_t'(stride_a);
        if (clr || !(mode == MODE_NORMAL || is_seq_mode(mode))) begin
            m_inner[0] = '0;
            m_outer[0] = '0;
        end else if (mode == MODE_NORMAL) begin
            if (add_a)
                m_inner[0] = m_inner[0] + 1'b1;
        end else if (mac_en) begin
            if (f[3] || (f[2] && mode == MODE_ASE)) begin
                m_inner[0] = '0;
                m_outer[0] = '0;
            end else if (f[2]) begin
                m_outer[0] = m_outer[0] + 1'b1;
                if (mode == MODE_SAE)
                    m_inner[0] = '0;
            end else if (f[1] || (f[0] && mode != MODE_ASE)) begin
                m_inner[0] = '0;
            end else begin
                m_inner[0] = m_inner[0] + step;
            end
        end
    endtask

    task automatic update_b(input full_t f);
        if (clr) begin
            m_inner[1] = '0;
            m_outer[1] = '0;
        end else if (mac_en) begin
            if (!(is_seq_mode(mode) || mode == MODE_CBS) || f[3] ||
                ((mode == MODE_SAE || mode == MODE_SBE) && (f[2] || f[1]))) begin
                m_inner[1] = '0;
                m_outer[1] = '0;
            end else if (f[2] || f[1]) begin
                if (mode == MODE_CBS || f[2]) begin
                    m_outer[1] = m_outer[1] + 1'b1;
                    if (mode == MODE_CBS)
                        cbs_outer_steps++;
                end
                if (f[1] && !(f[2] && mode == MODE_CBS))
                    m_inner[1] = '0;
            end else if (f[0]) begin
                m_inner[1] = m_inner[1] + 1'b1;
            end else if (mode == MODE_SAE || mode == MODE_SBE) begin
                m_inner[1] = m_inner[1] + addr_t'(stride_b);
            end
        end
    endtask

    always @(posedge clk or negedge rstn) begin : model_step
        full_t fa;
        full_t fb;
        if (!rstn) begin
            reset_model();
        end else begin
            fa = full_of(0);    // flags before the edge
            fb = full_of(1);
            update_a(fa);
            update_b(fb);
            advance_counters(0, add_a);
            advance_counters(1, add_b);
        end
    end

    task automatic stop_with_failure();
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_addr(input addr_t exp, input addr_t act, input string ch);
        if (act !== exp) begin
            $display("error at %0t ns: addr_%s is %h, expected %h", $time, ch, act, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_full(input full_t exp, input full_t act, input string ch);
        if (act !== exp) begin
            $display("error at %0t ns: full_%s is %b, expected %b", $time, ch, act, exp);
            stop_with_failure();
        end
    endtask

    // wait for the falling edge, then compare before the next drive
    task automatic tick();
        @(negedge clk);
        check_addr(model_addr(0), addr_a, "a");
        check_addr(model_addr(1), addr_b, "b");
        check_full(full_of(0), full_a, "a");
        check_full(full_of(1), full_b, "b");
    endtask

    task automatic drive_strobes(input int pct);
        add_a  = ($urandom_range(99) < pct);
        add_b  = ($urandom_range(99) < pct);
        mac_en = ($urandom_range(1) != 0);
    endtask

    task automatic apply_reset(input int max_limit);
        rstn     = 1'b0;
        add_a    = 1'b0;
        add_b    = 1'b0;
        clr      = 1'b0;
        mac_en   = 1'b0;
        base_a   = addr_t'($urandom);
        base_b   = addr_t'($urandom);
        stride_a = stride_t'($urandom);
        stride_b = stride_t'($urandom);
        a_loop0_max = count_t'($urandom_range(max_limit));
        a_loop1_max = count_t'($urandom_range(max_limit));
        a_loop2_max = count_t'($urandom_range(max_limit));
        a_loop3_max = count_t'($urandom_range(max_limit));
        b_loop0_max = count_t'($urandom_range(max_limit));
        b_loop1_max = count_t'($urandom_range(max_limit));
        b_loop2_max = count_t'($urandom_range(max_limit));
        b_loop3_max = count_t'($urandom_range(max_limit));
        repeat (RESET_CYCLES) tick();
        rstn = 1'b1;
        tick();
        check_addr(base_a, addr_a, "a");
        check_addr(base_b, addr_b, "b");
        check_full(reset_full(0), full_a, "a");
        check_full(reset_full(1), full_b, "b");
    endtask

    task automatic wrap_test();
        mode = MODE_NORMAL;
        apply_reset(3);
        repeat (WRAP_CYCLES) begin
            drive_strobes(75);
            tick();
        end
        if (wraps[0] < 2 || wraps[1] < 2) begin
            $display("loop nests wrapped %0d and %0d times, too few", wraps[0], wraps[1]);
            stop_with_failure();
        end
    endtask

    task automatic normal_test();
        addr_t exp_a;
        full_t held_a;
        full_t held_b;
        mode = MODE_NORMAL;
        apply_reset(3);
        exp_a = base_a;
        repeat (NORMAL_CYCLES) begin
            drive_strobes(50);
            exp_a = exp_a + addr_t'(add_a);     // one per strobe
            tick();
            check_addr(exp_a, addr_a, "a");
            check_addr(base_b, addr_b, "b");
        end
        add_a  = 1'b0;
        add_b  = 1'b0;
        clr    = 1'b1;
        held_a = full_of(0);
        held_b = full_of(1);
        tick();
        clr = 1'b0;
        check_addr(base_a, addr_a, "a");
        check_addr(base_b, addr_b, "b");
        check_full(held_a, full_a, "a");
        check_full(held_b, full_b, "b");
    endtask

    task automatic sequence_test(input mac_mode_e m);
        mode = m;
        apply_reset(3);
        repeat (SEQ_CYCLES) begin
            drive_strobes(60);
            if ($urandom_range(15) == 0) begin
                stride_a = stride_t'($urandom);
                stride_b = stride_t'($urandom);
            end
            tick();
        end
    endtask

    task automatic cbs_test();
        mode = MODE_CBS;
        apply_reset(2);
        repeat (CBS_CYCLES) begin
            drive_strobes(60);
            tick();
            check_addr(base_a, addr_a, "a");
        end
        if (cbs_outer_steps == 0) begin
            $display("channel b outer offset never advanced in CBS mode");
            stop_with_failure();
        end
    endtask

    task automatic mixed_test();
        mode = MODE_ASE;
        apply_reset(3);
        repeat (MIXED_CYCLES) begin
            if ($urandom_range(15) == 0)
                mode = mac_mode_e'($urandom_range(7));   // unused codes too
            clr = ($urandom_range(19) == 0);
            drive_strobes(60);
            if ($urandom_range(31) == 0)
                stride_a = stride_t'($urandom);
            tick();
        end
        clr = 1'b0;
    endtask

    initial begin
        #(2 * TOTAL_CYCLES * CLK_PERIOD);
        $display("simulation timed out before all tests finished");
        stop_with_failure();
    end

    initial begin
        seed_val = $urandom(33);
        clk      = 1'b0;
        rstn     = 1'b0;
        mode     = MODE_NORMAL;
        apply_reset(1);     // many zero maximums
        wrap_test();
        normal_test();
        sequence_test(MODE_ASE);
        sequence_test(MODE_SAE);
        sequence_test(MODE_SBE);
        cbs_test();
        mixed_test();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: src/agu_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AGU top: loop nests and offset sequencers for operand
// channels a and b of the MAC engine
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module agu_top (
    input  logic               clk,
    input  logic               rstn,

    // control
    input  logic               add_a,     // channel a step strobe
    input  logic               add_b,     // channel b step strobe
    input  logic               clr,
    input  agu_pkg::mac_mode_e mode,
    input  logic               mac_en,

    // channel a settings
    input  agu_pkg::addr_t     base_a,
    input  agu_pkg::stride_t   stride_a,
    input  agu_pkg::count_t    a_loop0_max,
    input  agu_pkg::count_t    a_loop1_max,
    input  agu_pkg::count_t    a_loop2_max,
    input  agu_pkg::count_t    a_loop3_max,

    // channel b settings
    input  agu_pkg::addr_t     base_b,
    input  agu_pkg::stride_t   stride_b,
    input  agu_pkg::count_t    b_loop0_max,
    input  agu_pkg::count_t    b_loop1_max,
    input  agu_pkg::count_t    b_loop2_max,
    input  agu_pkg::count_t    b_loop3_max,

    output agu_pkg::full_t     full_a,
    output agu_pkg::full_t     full_b,
    output agu_pkg::addr_t     addr_a,
    output agu_pkg::addr_t     addr_b
);

    import agu_pkg::*;

    full_t loop_full_a;
    full_t loop_full_b;

    assign full_a = loop_full_a;
    assign full_b = loop_full_b;

    agu_loop_nest loop_a_i (
        .clk       (clk),
        .rstn      (rstn),
        .step      (add_a),
        .loop0_max (a_loop0_max),
        .loop1_max (a_loop1_max),
        .loop2_max (a_loop2_max),
        .loop3_max (a_loop3_max),
        .full      (loop_full_a)
    );

    agu_loop_nest loop_b_i (
        .clk       (clk),
        .rstn      (rstn),
        .step      (add_b),
        .loop0_max (b_loop0_max),
        .loop1_max (b_loop1_max),
        .loop2_max (b_loop2_max),
        .loop3_max (b_loop3_max),
        .full      (loop_full_b)
    );

    // add_a drives both the loop nest and the normal-mode step
    agu_offset_a offset_a_i (
        .clk    (clk),
        .rstn   (rstn),
        .clr    (clr),
        .add    (add_a),
        .mac_en (mac_en),
        .mode   (mode),
        .full   (loop_full_a),
        .base   (base_a),
        .stride (stride_a),
        .addr   (addr_a)
    );

    agu_offset_b offset_b_i (
        .clk    (clk),
        .rstn   (rstn),
        .clr    (clr),
        .mac_en (mac_en),
        .mode   (mode),
        .full   (loop_full_b),
        .base   (base_b),
        .stride (stride_b),
        .addr   (addr_b)
    );

endmodule

// File: src/agu_offset_b.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AGU channel b: offset sequencer driven by the loop full flags
// and mac_en, and the operand address as base plus offsets
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "agu_settings.svh"

module agu_offset_b (
    input  logic               clk,
    input  logic               rstn,
    input  logic               clr,       // zero both offsets
    input  logic               mac_en,    // low freezes every mode
    input  agu_pkg::mac_mode_e mode,
    input  agu_pkg::full_t     full,
    input  agu_pkg::addr_t     base,
    input  agu_pkg::stride_t   stride,
    output agu_pkg::addr_t     addr
);

    import agu_pkg::*;

    addr_t inner;
    addr_t outer;
    addr_t stride_ext;

    assign stride_ext = {{(`AGU_ADDR_W - `AGU_STRIDE_W){1'b0}}, stride};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            inner <= '0;
            outer <= '0;
        end else if (clr) begin
            inner <= '0;
            outer <= '0;
        end else if (mac_en) begin
            case (mode)
                MODE_ASE: begin
                    if (full[3]) begin
                        inner <= '0;
                        outer <= '0;
                    end else if (full[2]) begin
                        inner <= '0;
                        outer <= outer + 1'b1;
                    end else if (full[1]) begin
                        inner <= '0;
                    end else if (full[0]) begin
                        inner <= inner + 1'b1;
                    end
                end
                MODE_SAE,
                MODE_SBE: begin
                    if (full[3] || full[2] || full[1]) begin
                        inner <= '0;
                        outer <= '0;
                    end else if (full[0]) begin
                        inner <= inner + 1'b1;
                    end else begin
                        inner <= inner + stride_ext;
                    end
                end
                MODE_CBS: begin
                    if (full[3]) begin
                        inner <= '0;
                        outer <= '0;
                    end else if (full[2]) begin
                        outer <= outer + 1'b1;
                    end else if (full[1]) begin
                        inner <= '0;                // next row
                        outer <= outer + 1'b1;
                    end else if (full[0]) begin
                        inner <= inner + 1'b1;
                    end
                end
                default: begin
                    // normal and unused codes
                    inner <= '0;
                    outer <= '0;
                end
            endcase
        end
    end

    assign addr = base + inner + outer;

endmodule

// File: src/agu_offset_a.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AGU channel a: inner/outer offset sequencer per MAC mode and
// the operand address as base plus both offsets
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "agu_settings.svh"

module agu_offset_a (
    input  logic               clk,
    input  logic               rstn,
    input  logic               clr,       // zero both offsets
    input  logic               add,       // normal mode step
    input  logic               mac_en,
    input  agu_pkg::mac_mode_e mode,
    input  agu_pkg::full_t     full,
    input  agu_pkg::addr_t     base,
    input  agu_pkg::stride_t   stride,
    output agu_pkg::addr_t     addr
);

    import agu_pkg::*;

    addr_t inner;
    addr_t outer;
    addr_t stride_ext;

    assign stride_ext = {{(`AGU_ADDR_W - `AGU_STRIDE_W){1'b0}}, stride};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            inner <= '0;
            outer <= '0;
        end else if (clr) begin
            inner <= '0;
            outer <= '0;
        end else begin
            case (mode)
                MODE_NORMAL: begin
                    if (add)
                        inner <= inner + 1'b1;      // mac_en not used here
                end
                MODE_ASE: begin
                    if (mac_en) begin
                        if (full[3] || full[2]) begin
                            inner <= '0;
                            outer <= '0;
                        end else if (full[1]) begin
                            inner <= '0;
                        end else begin
                            inner <= inner + stride_ext;
                        end
                    end
                end
                MODE_SAE: begin
                    if (mac_en) begin
                        if (full[3]) begin
                            inner <= '0;
                            outer <= '0;
                        end else if (full[2]) begin
                            inner <= '0;
                            outer <= outer + 1'b1;
                        end else if (full[1] || full[0]) begin
                            inner <= '0;
                        end else begin
                            inner <= inner + stride_ext;
                        end
                    end
                end
                MODE_SBE: begin
                    if (mac_en) begin
                        if (full[3]) begin
                            inner <= '0;
                            outer <= '0;
                        end else if (full[2]) begin
                            outer <= outer + 1'b1;  // inner held
                        end else if (full[1] || full[0]) begin
                            inner <= '0;
                        end else begin
                            inner <= inner + stride_ext;
                        end
                    end
                end
                default: begin
                    // CBS and unused codes park channel a at its base
                    inner <= '0;
                    outer <= '0;
                end
            endcase
        end
    end

    assign addr = base + inner + outer;

endmodule

// File: src/agu_loop_nest.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AGU loop nest: four counters stepping as an odometer with a
// wrap per level, plus the cumulative loop full flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "agu_settings.svh"

module agu_loop_nest (
    input  logic            clk,
    input  logic            rstn,
    input  logic            step,       // advance level 0
    input  agu_pkg::count_t loop0_max,
    input  agu_pkg::count_t loop1_max,
    input  agu_pkg::count_t loop2_max,
    input  agu_pkg::count_t loop3_max,
    output agu_pkg::full_t  full
);

    import agu_pkg::*;

    count_t                     cnt   [`AGU_LOOP_DEPTH];
    count_t                     max_v [`AGU_LOOP_DEPTH];
    logic [`AGU_LOOP_DEPTH-1:0] at_max;
    logic [`AGU_LOOP_DEPTH-1:0] adv;

    assign max_v[0] = loop0_max;
    assign max_v[1] = loop1_max;
    assign max_v[2] = loop2_max;
    assign max_v[3] = loop3_max;

    genvar lvl;

    generate
        for (lvl = 0; lvl < `AGU_LOOP_DEPTH; lvl++) begin : g_level

            assign at_max[lvl] = (cnt[lvl] == max_v[lvl]);

            if (lvl == 0) begin : g_first
                assign full[lvl] = at_max[lvl];
                assign adv[lvl]  = step;
            end else begin : g_next
                // level k only carries in when all lower levels sit at max
                assign full[lvl] = full[lvl-1] & at_max[lvl];
                assign adv[lvl]  = step & full[lvl-1];
            end

            always_ff @(posedge clk or negedge rstn) begin
                if (!rstn) begin
                    cnt[lvl] <= '0;
                end else if (adv[lvl]) begin
                    if (at_max[lvl])
                        cnt[lvl] <= '0;             // wrap
                    else
                        cnt[lvl] <= cnt[lvl] + 1'b1;
                end
            end

        end
    endgenerate

endmodule

// File: src/agu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AGU package: address, count, stride and flag types and the
// MAC sequencing mode
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "agu_settings.svh"

package agu_pkg;

    // memory address, base or offset
    typedef logic [`AGU_ADDR_W-1:0] addr_t;

    // loop counter value or loop maximum
    typedef logic [`AGU_ADDR_W-1:0] count_t;

    // step added to the inner offset
    typedef logic [`AGU_STRIDE_W-1:0] stride_t;

    // cumulative full flags, bit k set when levels 0..k are at max
    typedef logic [`AGU_LOOP_DEPTH-1:0] full_t;

    // codes 5 to 7 are unused
    typedef enum logic [`AGU_MODE_W-1:0] {
        MODE_NORMAL = 3'd0,
        MODE_ASE    = 3'd1,
        MODE_SAE    = 3'd2,
        MODE_SBE    = 3'd3,
        MODE_CBS    = 3'd4
    } mac_mode_e;

endpackage

// File: include/agu_settings.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AGU settings: address, stride and mode widths plus the
// number of nested loop levels per operand channel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef AGU_SETTINGS_SVH
`define AGU_SETTINGS_SVH

// addresses, offsets, bases, loop counts and maximums
`define AGU_ADDR_W 13

// inner-loop stride
`define AGU_STRIDE_W 9

// mode code: normal, ASE, SAE, SBE, CBS
`define AGU_MODE_W 3

// nested loop levels per channel
`define AGU_LOOP_DEPTH 4

`endif
